/* mdc_defines.svh */
`ifndef MDC_DEFINES_SVH
`define MDC_DEFINES_SVH

//##########################################################################
// Codeword and decoded widths
//##########################################################################
`define MDC_CODE_W       15     // Protected element codeword
`define MDC_ELEM_W       11     // Signed matrix element
`define MDC_MODE_CODE_W  9      // Protected mode codeword
`define MDC_MODE_W       5      // Decoded mode field

//##########################################################################
// Matrix geometry
//##########################################################################
`define MDC_N_ELEM       16     // Elements per matrix, row-major
`define MDC_DIM          4      // Matrix side

// Decoded mode codes, anything else falls back to 2x2
`define MDC_MODE_2X2     5'b00100
`define MDC_MODE_3X3     5'b00110

//##########################################################################
// Result slots
//##########################################################################
`define MDC_DET2_W       23     // One 2x2 determinant
`define MDC_DET3_W       51     // One 3x3 determinant, sign-extended
`define MDC_OUT_W        207    // Whole output word
`define MDC_N_DET2       9      // Contiguous 2x2 submatrices
`define MDC_N_DET3       4      // Contiguous 3x3 submatrices
`define MDC_D3_PAD       3      // Zero bits above the 3x3 slots
`define MDC_DET_IDX_W    4      // Slot index

// Engine steps per determinant
`define MDC_STEPS2       2
`define MDC_STEPS3       9

`endif

/* mdc_pkg.sv */
`default_nettype none

`include "mdc_defines.svh"

package mdc_pkg;

    //##########################################################################
    // Scalar types
    //##########################################################################

    // One decoded matrix element
    typedef logic signed [`MDC_ELEM_W-1:0] elem_t;

    // Determinant of a 2x2 submatrix, also used for the 3x3 minors
    typedef logic signed [`MDC_DET2_W-1:0] det2_t;

    // Determinant of a 3x3 submatrix, wide enough for the output slot
    typedef logic signed [`MDC_DET3_W-1:0] det3_t;

    // Active mode after decoding
    typedef enum logic {
        MODE_2X2,
        MODE_3X3
    } mode_t;

    //##########################################################################
    // Output word
    //##########################################################################

    // Slot 0 sits at the MSB end and belongs to the top-left submatrix
    typedef union packed {
        det2_t [0:`MDC_N_DET2-1] d2;                // Nine 2x2 results
        struct packed {
            logic  [`MDC_D3_PAD-1:0]  pad;          // Always zero
            det3_t [0:`MDC_N_DET3-1] slot;          // Four 3x3 results
        } d3;
    } out_word_u;

endpackage

`default_nettype wire

/* hamming_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module hamming_decoder #(
    parameter  int DATA_W = 11,
    // Parity bit count, smallest p with 2**p >= DATA_W + p + 1
    localparam int PAR_W  = $clog2(DATA_W + $clog2(DATA_W + 1) + 1),
    localparam int CODE_W = DATA_W + PAR_W
) (
    input  logic [CODE_W-1:0] code,
    output logic [DATA_W-1:0] data
);

    logic [PAR_W-1:0]  syndrome;
    logic [CODE_W-1:0] fixed;

    // Position k counts from 1 at the MSB, so it lives at bit CODE_W-k
    always_comb begin
        syndrome = '0;
        for (int k = 1; k <= CODE_W; k++) begin
            if (code[CODE_W-k]) begin
                syndrome ^= PAR_W'(k);
            end
        end
    end

    // Flip the one position the syndrome points at
    always_comb begin
        for (int k = 1; k <= CODE_W; k++) begin
            fixed[CODE_W-k] = code[CODE_W-k] ^ (syndrome == PAR_W'(k));
        end
    end

    //##########################################################################
    // Data extraction
    //##########################################################################

    // Non power-of-two positions carry data, lowest position is the MSB
    always_comb begin
        int unsigned n;
        n    = 0;
        data = '0;
        for (int k = 1; k <= CODE_W; k++) begin
            if ((k & (k - 1)) != 0) begin
                data[DATA_W-1-n] = fixed[CODE_W-k];
                n++;
            end
        end
    end

endmodule

`default_nettype wire

/* mdc_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdc_defines.svh"

module mdc_loader
    import mdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  elem_t                  elem,
    input  logic [`MDC_MODE_W-1:0] mode_raw,
    output elem_t                  matrix [`MDC_N_ELEM],
    output mode_t                  mode,
    output logic                   matrix_full
);

    localparam int CNT_W = $clog2(`MDC_N_ELEM);

    logic [CNT_W-1:0] count;     // Elements taken so far
    mode_t            mode_dec;

    // Unknown codes, the 4x4 code among them, run as 2x2
    always_comb begin
        case (mode_raw)
            `MDC_MODE_2X2: mode_dec = MODE_2X2;
            `MDC_MODE_3X3: mode_dec = MODE_3X3;
            default:       mode_dec = MODE_2X2;
        endcase
    end

    //##########################################################################
    // Element counter and mode latch
    //##########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count       <= '0;
            mode        <= MODE_2X2;
            matrix_full <= 1'b0;
        end else begin
            // High right after the edge that stores element 16
            matrix_full <= in_valid && (count == CNT_W'(`MDC_N_ELEM - 1));
            if (in_valid) begin
                count <= count + 1'b1;      // Wraps back to zero after 16
                if (count == '0) begin
                    mode <= mode_dec;       // Mode comes with element 0 only
                end
            end else begin
                count <= '0;
            end
        end
    end

    //##########################################################################
    // Matrix store
    //##########################################################################

    // Row-major, element i lands in matrix[i]
    always_ff @(posedge clk) begin
        if (in_valid) begin
            matrix[count] <= elem;
        end
    end

endmodule

`default_nettype wire

/* mdc_det_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdc_defines.svh"

module mdc_det_engine
    import mdc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  elem_t                     matrix [`MDC_N_ELEM],
    input  mode_t                     mode,
    input  logic                      start,
    output logic                      det_valid,
    output logic [`MDC_DET_IDX_W-1:0] det_index,
    output det3_t                     det_value,
    output logic                      done
);

    // Sequencer state
    logic                      busy;
    logic [3:0]                step;       // Step inside one determinant
    logic [`MDC_DET_IDX_W-1:0] sub;        // Submatrix being computed
    logic [3:0]                base;       // Index of its top-left element
    logic [1:0]                col;        // Column of that corner

    // Per-mode limits
    logic [3:0]                last_step;
    logic [`MDC_DET_IDX_W-1:0] last_sub;
    logic [1:0]                last_col;
    logic [1:0]                sub_size;
    logic                      step_end;

    // Operand selection from the step table
    logic [3:0]                a_off;
    logic [3:0]                b_off;
    logic [3:0]                a_idx;
    logic [3:0]                b_idx;
    logic                      b_minor;
    logic [1:0]                minor_sel;
    logic                      acc_load;
    logic                      acc_neg;

    // Datapath
    elem_t                     op_a;
    det2_t                     op_b;
    logic signed [`MDC_ELEM_W+`MDC_DET2_W-1:0] prod;
    det3_t                     acc;
    det3_t                     acc_next;
    det2_t                     minor [3];  // Top-row minors of a 3x3

    always_comb begin
        if (mode == MODE_3X3) begin
            last_step = 4'(`MDC_STEPS3 - 1);
            last_sub  = `MDC_DET_IDX_W'(`MDC_N_DET3 - 1);
            last_col  = 2'(`MDC_DIM - 3);
            sub_size  = 2'd3;
        end else begin
            last_step = 4'(`MDC_STEPS2 - 1);
            last_sub  = `MDC_DET_IDX_W'(`MDC_N_DET2 - 1);
            last_col  = 2'(`MDC_DIM - 2);
            sub_size  = 2'd2;
        end
    end

    assign step_end = (step == last_step);

    //##########################################################################
    // Step table
    //##########################################################################

    // Offsets are 4*row + col relative to the submatrix corner
    always_comb begin
        a_off     = 4'd0;
        b_off     = 4'd0;
        b_minor   = 1'b0;
        minor_sel = 2'd0;
        acc_load  = 1'b0;
        acc_neg   = 1'b0;
        if (mode == MODE_2X2) begin
            if (!step[0]) begin
                a_off    = 4'd0;                       // a00 * a11
                b_off    = 4'd5;
                acc_load = 1'b1;
            end else begin
                a_off    = 4'd1;                       // minus a01 * a10
                b_off    = 4'd4;
                acc_neg  = 1'b1;
            end
        end else begin
            case (step)
                4'd0: begin a_off = 4'd5; b_off = 4'd10; acc_load = 1'b1; end
                4'd1: begin a_off = 4'd6; b_off = 4'd9;  acc_neg  = 1'b1; end
                4'd2: begin a_off = 4'd4; b_off = 4'd10; acc_load = 1'b1; end
                4'd3: begin a_off = 4'd6; b_off = 4'd8;  acc_neg  = 1'b1; end
                4'd4: begin a_off = 4'd4; b_off = 4'd9;  acc_load = 1'b1; end
                4'd5: begin a_off = 4'd5; b_off = 4'd8;  acc_neg  = 1'b1; end
                // Expansion along the top row
                4'd6: begin
                    a_off     = 4'd0;
                    b_minor   = 1'b1;
                    minor_sel = 2'd0;
                    acc_load  = 1'b1;
                end
                4'd7: begin
                    a_off     = 4'd1;
                    b_minor   = 1'b1;
                    minor_sel = 2'd1;
                    acc_neg   = 1'b1;
                end
                default: begin
                    a_off     = 4'd2;
                    b_minor   = 1'b1;
                    minor_sel = 2'd2;
                end
            endcase
        end
    end

    //##########################################################################
    // Shared multiply-accumulate
    //##########################################################################

    assign a_idx = base + a_off;
    assign b_idx = base + b_off;
    assign op_a  = matrix[a_idx];
    assign op_b  = b_minor ? minor[minor_sel] : det2_t'(matrix[b_idx]);
    assign prod  = op_a * op_b;

    always_comb begin
        if (acc_load) begin
            acc_next = det3_t'(prod);
        end else if (acc_neg) begin
            acc_next = acc - prod;
        end else begin
            acc_next = acc + prod;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            acc <= acc_next;
            // Odd steps below 6 finish minors 0, 1 and 2
            if (mode == MODE_3X3 && step[0] && step < 4'd6) begin
                minor[step[2:1]] <= acc_next[`MDC_DET2_W-1:0];
            end
            if (step_end) begin
                det_value <= acc_next;
            end
        end
    end

    //##########################################################################
    // Sequencer
    //##########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            step      <= 4'd0;
            sub       <= '0;
            base      <= 4'd0;
            col       <= 2'd0;
            det_valid <= 1'b0;
            det_index <= '0;
            done      <= 1'b0;
        end else begin
            det_valid <= 1'b0;
            done      <= det_valid && (det_index == last_sub);  // After the last slot
            if (start) begin
                busy <= 1'b1;
                step <= 4'd0;
                sub  <= '0;
                base <= 4'd0;
                col  <= 2'd0;
            end else if (busy) begin
                if (step_end) begin
                    step      <= 4'd0;
                    det_valid <= 1'b1;
                    det_index <= sub;
                    sub       <= sub + 1'b1;
                    if (sub == last_sub) begin
                        busy <= 1'b0;
                    end
                    // Next corner in row-major order
                    if (col == last_col) begin
                        col  <= 2'd0;
                        base <= base + {2'b00, sub_size};
                    end else begin
                        col  <= col + 1'b1;
                        base <= base + 1'b1;
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* mdc_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdc_defines.svh"

module mdc_result
    import mdc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  mode_t                     mode,
    input  logic                      det_valid,
    input  logic [`MDC_DET_IDX_W-1:0] det_index,
    input  det3_t                     det_value,
    input  logic                      done,
    output logic                      out_valid,
    output out_word_u                 out_data
);

    out_word_u staging;     // Filled slot by slot while the engine runs

    //##########################################################################
    // Slot staging
    //##########################################################################

    always_ff @(posedge clk) begin
        if (det_valid) begin
            if (mode == MODE_3X3) begin
                staging.d3.slot[det_index[1:0]] <= det_value;
                staging.d3.pad                  <= '0;
            end else begin
                // 2x2 results fit in 23 bits
                staging.d2[det_index] <= det_value[`MDC_DET2_W-1:0];
            end
        end
    end

    //##########################################################################
    // Output register
    //##########################################################################

    // One cycle of valid data, zero the rest of the time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= done;
            if (done) begin
                out_data <= staging;
            end else begin
                out_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* mdc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdc_defines.svh"

module mdc_top
    import mdc_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [`MDC_CODE_W-1:0]      in_data,
    input  logic [`MDC_MODE_CODE_W-1:0] in_mode,
    output logic                        out_valid,
    output logic [`MDC_OUT_W-1:0]       out_data
);

    elem_t                     elem;                  // Corrected element
    logic [`MDC_MODE_W-1:0]    mode_raw;              // Corrected mode field
    elem_t                     matrix [`MDC_N_ELEM];
    mode_t                     mode;
    logic                      matrix_full;
    logic                      det_valid;
    logic [`MDC_DET_IDX_W-1:0] det_index;
    det3_t                     det_value;
    logic                      done;

    //##########################################################################
    // Input decoders
    //##########################################################################

    hamming_decoder #(.DATA_W(`MDC_ELEM_W)) i_data_dec (
        .code (in_data),
        .data (elem)
    );

    hamming_decoder #(.DATA_W(`MDC_MODE_W)) i_mode_dec (
        .code (in_mode),
        .data (mode_raw)
    );

    //##########################################################################
    // Core
    //##########################################################################

    mdc_loader i_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .elem        (elem),
        .mode_raw    (mode_raw),
        .matrix      (matrix),
        .mode        (mode),
        .matrix_full (matrix_full)
    );

    mdc_det_engine i_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .matrix    (matrix),
        .mode      (mode),
        .start     (matrix_full),
        .det_valid (det_valid),
        .det_index (det_index),
        .det_value (det_value),
        .done      (done)
    );

    mdc_result i_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .mode      (mode),
        .det_valid (det_valid),
        .det_index (det_index),
        .det_value (det_value),
        .done      (done),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

/* tb_mdc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdc_defines.svh"

module tb_mdc;

    localparam int           TIMEOUT_CYCLES = 200;     // Longest mode needs well under this
    localparam logic [4:0]   MODE_CODE_4X4  = 5'b10110; // Unsupported code, runs as 2x2

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic [`MDC_CODE_W-1:0]      in_data;
    logic [`MDC_MODE_CODE_W-1:0] in_mode;
    logic                        out_valid;
    logic [`MDC_OUT_W-1:0]       out_data;

    logic signed [`MDC_ELEM_W-1:0] mat [`MDC_N_ELEM];  // Matrix under test, row-major
    logic [31:0]                   rng;

    mdc_top i_mdc_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #50 clk = ~clk;

    //##########################################################################
    // Helpers
    //##########################################################################

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Position k from 1 at the MSB, parity at 1, 2, 4 and 8
    function automatic logic [14:0] hamming_encode(input logic [10:0] data, input int data_w);
        logic [14:0] code;
        int          code_w;
        int          n;
        int          syn;
        code   = '0;
        code_w = data_w + 4;
        n      = 0;
        syn    = 0;
        for (int k = 1; k <= code_w; k++) begin
            if ((k & (k - 1)) != 0) begin
                code[code_w-k] = data[data_w-1-n];
                n++;
                if (code[code_w-k]) begin
                    syn = syn ^ k;
                end
            end
        end
        // Parity bits cancel the data syndrome
        for (int p = 1; p <= 8; p = p * 2) begin
            if ((syn & p) != 0) begin
                code[code_w-p] = 1'b1;
            end
        end
        return code;
    endfunction

    function automatic longint elem_at(input int r, input int c);
        return longint'(mat[4*r+c]);
    endfunction

    function automatic longint det2_ref(input int r, input int c);
        return elem_at(r, c) * elem_at(r + 1, c + 1) - elem_at(r, c + 1) * elem_at(r + 1, c);
    endfunction

    // Cofactor expansion along the top row
    function automatic longint det3_ref(input int r, input int c);
        longint m0;
        longint m1;
        longint m2;
        m0 = elem_at(r + 1, c + 1) * elem_at(r + 2, c + 2)
           - elem_at(r + 1, c + 2) * elem_at(r + 2, c + 1);
        m1 = elem_at(r + 1, c) * elem_at(r + 2, c + 2)
           - elem_at(r + 1, c + 2) * elem_at(r + 2, c);
        m2 = elem_at(r + 1, c) * elem_at(r + 2, c + 1)
           - elem_at(r + 1, c + 1) * elem_at(r + 2, c);
        return elem_at(r, c) * m0 - elem_at(r, c + 1) * m1 + elem_at(r, c + 2) * m2;
    endfunction

    function automatic int slot_top(input bit is3, input int s);
        if (is3) begin
            return `MDC_OUT_W - 1 - `MDC_D3_PAD - `MDC_DET3_W * s;
        end
        return `MDC_OUT_W - 1 - `MDC_DET2_W * s;
    endfunction

    // Slot 0 at the MSB end, corners in row-major order
    function automatic logic [`MDC_OUT_W-1:0] expected_word(input bit is3);
        logic [`MDC_OUT_W-1:0] w;
        w = '0;
        if (is3) begin
            for (int s = 0; s < `MDC_N_DET3; s++) begin
                w[slot_top(1'b1, s) -: `MDC_DET3_W] = `MDC_DET3_W'(det3_ref(s / 2, s % 2));
            end
        end else begin
            for (int s = 0; s < `MDC_N_DET2; s++) begin
                w[slot_top(1'b0, s) -: `MDC_DET2_W] = `MDC_DET2_W'(det2_ref(s / 3, s % 3));
            end
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic fill_random_matrix();
        for (int i = 0; i < `MDC_N_ELEM; i++) begin
            rng    = xorshift32(rng);
            mat[i] = rng[`MDC_ELEM_W-1:0];
        end
    endtask

    //##########################################################################
    // Drive and check
    //##########################################################################

    task automatic send_matrix(input logic [4:0] mode_code, input bit corrupt);
        logic [14:0] code;
        logic [14:0] mode_full;
        logic [8:0]  mcode;
        for (int i = 0; i < `MDC_N_ELEM; i++) begin
            @(posedge clk);
            #1;
            code = hamming_encode(mat[i], `MDC_ELEM_W);
            if (corrupt) begin
                rng  = xorshift32(rng);
                code = code ^ (15'b1 << (rng % 15));  // One flipped bit per codeword
            end
            rng = xorshift32(rng);
            if (i == 0) begin
                mode_full = hamming_encode({6'b0, mode_code}, `MDC_MODE_W);
                mcode     = mode_full[8:0];
                if (corrupt) begin
                    mcode = mcode ^ (9'b1 << (rng % 9));
                end
            end else begin
                mcode = rng[8:0];       // Noise, the mode is only read with element 0
            end
            in_valid = 1'b1;
            in_data  = code;
            in_mode  = mcode;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
    endtask

    task automatic wait_out_valid();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (out_valid !== 1'b1 && cycles < TIMEOUT_CYCLES);
        assert (out_valid === 1'b1) else begin
            $display("Timeout: out_valid did not rise after the matrix was sent");
            abort_run();
        end
    endtask

    task automatic check_slots(input bit is3);
        logic [`MDC_OUT_W-1:0] exp;
        int                    top;
        exp = expected_word(is3);
        if (is3) begin
            assert (out_data[`MDC_OUT_W-1 -: `MDC_D3_PAD] == '0) else begin
                $display("Fail out_data pad bits: expected %h, got %h",
                         3'h0, out_data[`MDC_OUT_W-1 -: `MDC_D3_PAD]);
                abort_run();
            end
            for (int s = 0; s < `MDC_N_DET3; s++) begin
                top = slot_top(1'b1, s);
                assert (out_data[top -: `MDC_DET3_W] == exp[top -: `MDC_DET3_W]) else begin
                    $display("Fail out_data slot %0d: expected %h, got %h", s,
                             exp[top -: `MDC_DET3_W], out_data[top -: `MDC_DET3_W]);
                    abort_run();
                end
            end
        end else begin
            for (int s = 0; s < `MDC_N_DET2; s++) begin
                top = slot_top(1'b0, s);
                assert (out_data[top -: `MDC_DET2_W] == exp[top -: `MDC_DET2_W]) else begin
                    $display("Fail out_data slot %0d: expected %h, got %h", s,
                             exp[top -: `MDC_DET2_W], out_data[top -: `MDC_DET2_W]);
                    abort_run();
                end
            end
        end
    endtask

    task automatic check_idle_outputs();
        assert (out_valid === 1'b0) else begin
            $display("Fail out_valid: expected %h, got %h", 1'b0, out_valid);
            abort_run();
        end
        assert (out_data === '0) else begin
            $display("Fail out_data: expected %h, got %h", {`MDC_OUT_W{1'b0}}, out_data);
            abort_run();
        end
    endtask

    // One matrix end to end, valid must drop again after one cycle
    task automatic run_case(input logic [4:0] mode_code, input bit is3, input bit corrupt);
        send_matrix(mode_code, corrupt);
        wait_out_valid();
        check_slots(is3);
        @(negedge clk);
        check_idle_outputs();
    endtask

    //##########################################################################
    // Tests
    //##########################################################################

    task automatic test_idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_idle_outputs();
        end
    endtask

    task automatic test_random_2x2();
        repeat (4) begin
            fill_random_matrix();
            run_case(`MDC_MODE_2X2, 1'b0, 1'b0);
        end
    endtask

    task automatic test_random_3x3();
        repeat (4) begin
            fill_random_matrix();
            run_case(`MDC_MODE_3X3, 1'b1, 1'b0);
        end
    endtask

    task automatic test_single_bit_errors();
        repeat (3) begin
            fill_random_matrix();
            run_case(`MDC_MODE_2X2, 1'b0, 1'b1);
            fill_random_matrix();
            run_case(`MDC_MODE_3X3, 1'b1, 1'b1);
        end
    endtask

    task automatic test_extreme_values();
        // Checkerboard of -1024 and 1023
        for (int i = 0; i < `MDC_N_ELEM; i++) begin
            mat[i] = (((i >> 2) + i) & 1) != 0 ? 11'h3ff : 11'h400;
        end
        run_case(`MDC_MODE_2X2, 1'b0, 1'b0);
        run_case(`MDC_MODE_3X3, 1'b1, 1'b0);
        repeat (3) begin
            for (int i = 0; i < `MDC_N_ELEM; i++) begin
                rng    = xorshift32(rng);
                mat[i] = rng[0] ? 11'h3ff : 11'h400;
            end
            run_case(`MDC_MODE_2X2, 1'b0, 1'b0);
            run_case(`MDC_MODE_3X3, 1'b1, 1'b0);
            run_case(MODE_CODE_4X4, 1'b0, 1'b0);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        rng      = 32'h7e90_2bbb;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_idle_after_reset();
        test_random_2x2();
        test_random_3x3();
        test_single_bit_errors();
        test_extreme_values();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
mdc_pkg.sv
hamming_decoder.sv
mdc_loader.sv
mdc_det_engine.sv
mdc_result.sv
mdc_top.sv
tb_mdc.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_mdc \
    && ./obj_dir/Vtb_mdc > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
